// File: hdl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int NUM_ISA_REGS = 32;     // Architectural registers per file
    localparam int PHYS_REG_W   = 6;      // 64 physical registers per file
    localparam int CKPT_W       = 3;      // Label space for up to 8 checkpoints
    localparam int AREG_W       = 5;      // log2 of NUM_ISA_REGS

    //////////////////////////////
    // Register and label types
    //////////////////////////////

    typedef logic [PHYS_REG_W-1:0] phreg_t;           // Integer physical register
    typedef logic [PHYS_REG_W-1:0] phfreg_t;          // FP physical register
    typedef logic [AREG_W-1:0]     areg_t;            // Architectural register
    typedef logic [CKPT_W-1:0]     checkpoint_ptr_t;  // Checkpoint label

    // One instruction entering rename
    typedef struct packed {
        areg_t src1;
        areg_t src2;
        logic  src1_fp;           // Source 1 lives in the FP file
        logic  src2_fp;
        areg_t dst;
        logic  dst_we;            // Instruction writes a destination
        logic  dst_fp;            // Destination file select
        logic  do_checkpoint;     // Branch, take a checkpoint after renaming
    } rename_req_t;

    // Renamed instruction
    typedef struct packed {
        logic [PHYS_REG_W-1:0] psrc1;
        logic [PHYS_REG_W-1:0] psrc2;
        logic [PHYS_REG_W-1:0] pdst;       // Newly allocated register
        logic [PHYS_REG_W-1:0] old_pdst;   // Previous mapping, freed at commit
        logic                  dst_valid;
        checkpoint_ptr_t       checkpoint; // Label to recover for this branch
    } rename_rsp_t;

    // One retiring instruction
    typedef struct packed {
        logic                  valid;
        logic                  fp;
        areg_t                 dst;
        logic [PHYS_REG_W-1:0] pdst;       // Becomes the committed mapping
        logic [PHYS_REG_W-1:0] old_pdst;   // Goes back to the free list
    } commit_t;

endpackage

`default_nettype wire

// File: hdl/free_list.sv
`timescale 1ns/100ps
`default_nettype none

module free_list #(
    parameter int  NUM_CHECKPOINTS = 4,
    parameter type reg_t           = rename_pkg::phreg_t
) (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire logic                        read_head_i,          // Allocate one register
    input  wire logic [1:0]                  add_free_register_i,  // Per commit slot
    input  wire reg_t [1:0]                  free_register_i,
    input  wire logic                        do_checkpoint_i,
    input  wire logic                        do_recover_i,
    input  wire logic                        delete_checkpoint_i,  // Oldest one retires
    input  wire rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    input  wire logic                        commit_roll_back_i,
    output reg_t                             new_register_o,
    output rename_pkg::checkpoint_ptr_t      checkpoint_o,
    output logic                             out_of_checkpoints_o,
    output logic                             empty_o
);

    localparam int NUM_ENTRIES = rename_pkg::NUM_ISA_REGS;  // Spare registers per file
    localparam int PTR_W       = $clog2(NUM_ENTRIES);
    localparam int VER_W       = $clog2(NUM_CHECKPOINTS);

    reg_t             buffer_q   [NUM_ENTRIES];       // Circular buffer of free registers
    logic [PTR_W-1:0] head_q     [NUM_CHECKPOINTS];   // One head per version
    logic [PTR_W:0]   num_regs_q [NUM_CHECKPOINTS];   // Free count, one bit wider
    logic [PTR_W-1:0] tail_q;                         // Shared by every version
    logic [VER_W-1:0] version_q;                      // Live version
    logic [VER_W-1:0] version_tail_q;                 // Oldest live checkpoint
    logic [VER_W:0]   num_ckpt_q;

    logic             we0;
    logic             we1;
    logic             read_en;
    logic             ckpt_en;
    logic [1:0]       num_frees;
    logic [PTR_W:0]   cur_regs;
    logic [PTR_W:0]   cur_regs_nxt;
    logic [PTR_W-1:0] cur_head_nxt;
    logic [VER_W-1:0] version_nxt;
    logic [VER_W-1:0] version_tail_nxt;
    logic [VER_W-1:0] recover_ver;

    //////////////////////////////
    // Strobes
    //////////////////////////////

    assign we0       = add_free_register_i[0] & ~commit_roll_back_i;  // Frees dropped on flush
    assign we1       = add_free_register_i[1] & ~commit_roll_back_i;
    assign num_frees = {1'b0, we0} + {1'b0, we1};
    assign cur_regs  = num_regs_q[version_q];

    // Allocation needs a stored register or a same-cycle free
    assign read_en = read_head_i & ((cur_regs != '0) | we0 | we1)
                   & ~do_recover_i & ~commit_roll_back_i;

    // One copy stays spare for the live version
    assign ckpt_en = do_checkpoint_i & (num_ckpt_q < (VER_W+1)'(NUM_CHECKPOINTS - 1))
                   & ~do_recover_i & ~commit_roll_back_i;

    assign cur_regs_nxt     = cur_regs + (PTR_W+1)'(num_frees) - (PTR_W+1)'(read_en);
    assign cur_head_nxt     = head_q[version_q] + PTR_W'(read_en);
    assign version_nxt      = version_q + 1'b1;                 // Wraps over the copies
    assign version_tail_nxt = version_tail_q + VER_W'(delete_checkpoint_i);
    assign recover_ver      = recover_checkpoint_i[VER_W-1:0];

    //////////////////////////////
    // State update
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_q      <= '0;
            version_tail_q <= '0;
            num_ckpt_q     <= '0;
            tail_q         <= '0;              // Full buffer, tail meets head
            checkpoint_o   <= '0;
            for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                head_q[c]     <= '0;
                num_regs_q[c] <= (PTR_W+1)'(NUM_ENTRIES);
            end
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                buffer_q[i] <= reg_t'(i + NUM_ENTRIES);  // Spares 32 to 63
            end
        end else if (commit_roll_back_i) begin
            // Every non-committed register is free again
            version_q      <= '0;
            version_tail_q <= '0;
            num_ckpt_q     <= '0;
            head_q[0]      <= tail_q;
            num_regs_q[0]  <= (PTR_W+1)'(NUM_ENTRIES);
            checkpoint_o   <= '0;
        end else begin
            version_tail_q <= version_tail_nxt;
            checkpoint_o   <= rename_pkg::checkpoint_ptr_t'(version_q);  // Label before the edge

            if (we0) buffer_q[tail_q] <= free_register_i[0];
            if (we1) buffer_q[tail_q + PTR_W'(we0)] <= free_register_i[1];  // Packs behind slot 0
            tail_q <= tail_q + PTR_W'(num_frees);

            // A freed register is free in every version
            for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                num_regs_q[c] <= num_regs_q[c] + (PTR_W+1)'(num_frees);
            end

            if (do_recover_i) begin
                version_q  <= recover_ver;
                num_ckpt_q <= {1'b0, recover_ver - version_tail_nxt};  // Distance from oldest
            end else begin
                num_ckpt_q <= num_ckpt_q + (VER_W+1)'(ckpt_en)
                            - (VER_W+1)'(delete_checkpoint_i);
                head_q[version_q]     <= cur_head_nxt;   // Only the live version allocates
                num_regs_q[version_q] <= cur_regs_nxt;
                if (ckpt_en) begin
                    version_q               <= version_nxt;
                    head_q[version_nxt]     <= cur_head_nxt;  // Copy after this allocation
                    num_regs_q[version_nxt] <= cur_regs_nxt;
                end
            end
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    always_comb begin
        if (!read_en) begin
            new_register_o = '0;
        end else if ((cur_regs == '0) && we0) begin
            new_register_o = free_register_i[0];      // Bypass when empty
        end else if ((cur_regs == '0) && we1) begin
            new_register_o = free_register_i[1];
        end else begin
            new_register_o = buffer_q[head_q[version_q]];
        end
    end

    assign empty_o              = (cur_regs == '0) & ~we0 & ~we1;
    assign out_of_checkpoints_o = (num_ckpt_q == (VER_W+1)'(NUM_CHECKPOINTS - 1));

endmodule

`default_nettype wire

// File: hdl/rename_table.sv
`timescale 1ns/100ps
`default_nettype none

module rename_table #(
    parameter int  NUM_CHECKPOINTS = 4,
    parameter type reg_t           = rename_pkg::phreg_t
) (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire rename_pkg::areg_t           src1_i,
    input  wire rename_pkg::areg_t           src2_i,
    input  wire rename_pkg::areg_t           dst_i,
    input  wire logic                        dst_we_i,          // Install new_pdst_i for dst_i
    input  wire reg_t                        new_pdst_i,        // From the free list
    input  wire logic                        do_checkpoint_i,   // Already gated for room
    input  wire logic                        do_recover_i,
    input  wire rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    input  wire logic                        commit_roll_back_i,
    input  wire logic [1:0]                  commit_we_i,
    input  wire rename_pkg::areg_t [1:0]     commit_dst_i,
    input  wire reg_t [1:0]                  commit_pdst_i,
    output reg_t                             psrc1_o,
    output reg_t                             psrc2_o,
    output reg_t                             old_pdst_o
);

    localparam int NUM_REGS = rename_pkg::NUM_ISA_REGS;
    localparam int VER_W    = $clog2(NUM_CHECKPOINTS);

    reg_t             map_q    [NUM_CHECKPOINTS][NUM_REGS];  // Speculative map per version
    reg_t             commit_q [NUM_REGS];                   // Architectural state
    logic [VER_W-1:0] version_q;
    logic [VER_W-1:0] version_nxt;

    assign version_nxt = version_q + 1'b1;

    //////////////////////////////
    // Lookups
    //////////////////////////////

    // Sources see the map before this instruction's own write
    assign psrc1_o    = map_q[version_q][src1_i];
    assign psrc2_o    = map_q[version_q][src2_i];
    assign old_pdst_o = map_q[version_q][dst_i];

    //////////////////////////////
    // Map update
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_q <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                commit_q[r] <= reg_t'(r);            // Identity mapping
                for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                    map_q[c][r] <= reg_t'(r);
                end
            end
        end else begin
            // Retire in order, slot 1 is younger and wins
            if (!commit_roll_back_i) begin
                for (int k = 0; k < 2; k++) begin
                    if (commit_we_i[k]) commit_q[commit_dst_i[k]] <= commit_pdst_i[k];
                end
            end

            if (commit_roll_back_i) begin
                version_q <= '0;
                for (int r = 0; r < NUM_REGS; r++) begin
                    map_q[0][r] <= commit_q[r];
                end
            end else if (do_recover_i) begin
                version_q <= recover_checkpoint_i[VER_W-1:0];  // Copy is already intact
            end else begin
                if (dst_we_i) map_q[version_q][dst_i] <= new_pdst_i;
                if (do_checkpoint_i) begin
                    // Next slot gets the map including this rename
                    version_q <= version_nxt;
                    for (int r = 0; r < NUM_REGS; r++) begin
                        if (dst_we_i && (dst_i == rename_pkg::areg_t'(r))) begin
                            map_q[version_nxt][r] <= new_pdst_i;
                        end else begin
                            map_q[version_nxt][r] <= map_q[version_q][r];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rename_unit #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire logic                        rename_valid_i,
    input  wire rename_pkg::rename_req_t     rename_req_i,
    input  wire rename_pkg::commit_t [1:0]   commit_i,
    input  wire logic                        do_recover_i,
    input  wire rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    input  wire logic                        delete_checkpoint_i,
    input  wire logic                        commit_roll_back_i,
    output logic                             rsp_valid_o,
    output rename_pkg::rename_rsp_t          rename_rsp_o,
    output logic                             empty_int_o,
    output logic                             empty_fp_o,
    output logic                             out_of_checkpoints_o
);

    logic                         fire;        // Rename accepted this cycle
    logic                         int_alloc;
    logic                         fp_alloc;
    logic                         ckpt_go;
    logic                         int_ooc;
    logic [1:0]                   int_cmt;
    logic [1:0]                   fp_cmt;
    rename_pkg::areg_t [1:0]      cmt_dst;
    rename_pkg::phreg_t [1:0]     int_cmt_pdst;
    rename_pkg::phreg_t [1:0]     int_free_reg;
    rename_pkg::phfreg_t [1:0]    fp_cmt_pdst;
    rename_pkg::phfreg_t [1:0]    fp_free_reg;
    rename_pkg::phreg_t           int_new;
    rename_pkg::phreg_t           int_psrc1;
    rename_pkg::phreg_t           int_psrc2;
    rename_pkg::phreg_t           int_old;
    rename_pkg::phfreg_t          fp_new;
    rename_pkg::phfreg_t          fp_psrc1;
    rename_pkg::phfreg_t          fp_psrc2;
    rename_pkg::phfreg_t          fp_old;
    rename_pkg::checkpoint_ptr_t  int_ckpt;
    rename_pkg::rename_rsp_t      rsp_d;
    rename_pkg::rename_rsp_t      rsp_q;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    assign fire      = rename_valid_i & ~do_recover_i & ~commit_roll_back_i;  // Flush drops it
    assign int_alloc = fire & rename_req_i.dst_we & ~rename_req_i.dst_fp
                     & (rename_req_i.dst != '0);                           // x0 stays fixed
    assign fp_alloc  = fire & rename_req_i.dst_we & rename_req_i.dst_fp;
    assign ckpt_go   = fire & rename_req_i.do_checkpoint & ~out_of_checkpoints_o;  // Both files

    assign out_of_checkpoints_o = int_ooc;  // Lists move in step

    // Commit slots split by file
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            int_cmt[k]      = commit_i[k].valid & ~commit_i[k].fp & (commit_i[k].dst != '0);
            fp_cmt[k]       = commit_i[k].valid & commit_i[k].fp;
            cmt_dst[k]      = commit_i[k].dst;
            int_cmt_pdst[k] = commit_i[k].pdst;
            int_free_reg[k] = commit_i[k].old_pdst;
            fp_cmt_pdst[k]  = commit_i[k].pdst;
            fp_free_reg[k]  = commit_i[k].old_pdst;
        end
    end

    //////////////////////////////
    // Integer and FP pairs
    //////////////////////////////

    free_list #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .reg_t(rename_pkg::phreg_t)) u_int_free_list (
        .clk_i, .rstn_i,
        .read_head_i (int_alloc), .add_free_register_i (int_cmt),
        .free_register_i (int_free_reg), .do_checkpoint_i (ckpt_go),
        .do_recover_i, .delete_checkpoint_i, .recover_checkpoint_i, .commit_roll_back_i,
        .new_register_o (int_new), .checkpoint_o (int_ckpt),
        .out_of_checkpoints_o (int_ooc), .empty_o (empty_int_o)
    );

    free_list #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .reg_t(rename_pkg::phfreg_t)) u_fp_free_list (
        .clk_i, .rstn_i,
        .read_head_i (fp_alloc), .add_free_register_i (fp_cmt),
        .free_register_i (fp_free_reg), .do_checkpoint_i (ckpt_go),
        .do_recover_i, .delete_checkpoint_i, .recover_checkpoint_i, .commit_roll_back_i,
        .new_register_o (fp_new), .checkpoint_o (),           // Same label as integer
        .out_of_checkpoints_o (), .empty_o (empty_fp_o)       // Same count as integer
    );

    rename_table #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .reg_t(rename_pkg::phreg_t)) u_int_table (
        .clk_i, .rstn_i,
        .src1_i (rename_req_i.src1), .src2_i (rename_req_i.src2), .dst_i (rename_req_i.dst),
        .dst_we_i (int_alloc), .new_pdst_i (int_new), .do_checkpoint_i (ckpt_go),
        .do_recover_i, .recover_checkpoint_i, .commit_roll_back_i,
        .commit_we_i (int_cmt), .commit_dst_i (cmt_dst), .commit_pdst_i (int_cmt_pdst),
        .psrc1_o (int_psrc1), .psrc2_o (int_psrc2), .old_pdst_o (int_old)
    );

    rename_table #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .reg_t(rename_pkg::phfreg_t)) u_fp_table (
        .clk_i, .rstn_i,
        .src1_i (rename_req_i.src1), .src2_i (rename_req_i.src2), .dst_i (rename_req_i.dst),
        .dst_we_i (fp_alloc), .new_pdst_i (fp_new), .do_checkpoint_i (ckpt_go),
        .do_recover_i, .recover_checkpoint_i, .commit_roll_back_i,
        .commit_we_i (fp_cmt), .commit_dst_i (cmt_dst), .commit_pdst_i (fp_cmt_pdst),
        .psrc1_o (fp_psrc1), .psrc2_o (fp_psrc2), .old_pdst_o (fp_old)
    );

    //////////////////////////////
    // Response
    //////////////////////////////

    always_comb begin
        rsp_d            = '0;
        rsp_d.psrc1      = rename_req_i.src1_fp ? fp_psrc1 : int_psrc1;
        rsp_d.psrc2      = rename_req_i.src2_fp ? fp_psrc2 : int_psrc2;
        rsp_d.pdst       = fp_alloc ? fp_new : int_new;
        rsp_d.old_pdst   = rename_req_i.dst_fp ? fp_old : int_old;
        rsp_d.dst_valid  = int_alloc | fp_alloc;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_q <= rsp_d;                    // Payload, qualified by rsp_valid_o
    end

    // Free list label is already registered, so it lines up with rsp_q
    always_comb begin
        rename_rsp_o            = rsp_q;
        rename_rsp_o.checkpoint = int_ckpt;
    end

endmodule

`default_nettype wire

// File: verif/tb_rename_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit;

    localparam int NUM_CK       = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 600;      // Mixed traffic, no checkpoints
    localparam int CKPT_CYCLES  = 800;      // Branches, recovers and deletes
    localparam int RB_ROUNDS    = 4;
    localparam int RB_CYCLES    = 150;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 31 + RAND_CYCLES + CKPT_CYCLES
                                + RB_ROUNDS * (RB_CYCLES + 1) + 2;
    localparam int FL_DEPTH     = 8192;     // Unbounded history of freed registers

    logic                        clk_i;
    logic                        rstn_i;
    logic                        rename_valid;
    rename_pkg::rename_req_t     rename_req;
    rename_pkg::commit_t [1:0]   commit;
    logic                        do_recover;
    rename_pkg::checkpoint_ptr_t recover_ckpt;
    logic                        delete_ckpt;
    logic                        roll_back;
    logic                        rsp_valid;
    rename_pkg::rename_rsp_t     rsp;
    logic                        empty_int;
    logic                        empty_fp;
    logic                        ooc;

    rename_unit #(.NUM_CHECKPOINTS(NUM_CK)) u_rename_unit (
        .clk_i, .rstn_i,
        .rename_valid_i (rename_valid), .rename_req_i (rename_req), .commit_i (commit),
        .do_recover_i (do_recover), .recover_checkpoint_i (recover_ckpt),
        .delete_checkpoint_i (delete_ckpt), .commit_roll_back_i (roll_back),
        .rsp_valid_o (rsp_valid), .rename_rsp_o (rsp),
        .empty_int_o (empty_int), .empty_fp_o (empty_fp), .out_of_checkpoints_o (ooc)
    );

    //////////////////////////////
    // Reference model state
    //////////////////////////////

    rename_pkg::phreg_t fbuf      [2][FL_DEPTH];  // Every register ever freed, per file
    int                 fhead     [2];            // Next to allocate
    int                 ftail     [2];
    rename_pkg::phreg_t smap      [2][32];        // Speculative map
    rename_pkg::phreg_t cmap      [2][32];        // Committed map
    rename_pkg::phreg_t snap_map  [2][8][32];     // Snapshot per label
    int                 snap_head [2][8];
    int                 ck_lbl    [$];            // Live labels, oldest first
    int                 ck_seq    [$];            // Rename count at each branch
    rename_pkg::commit_t infl     [$];            // In-flight renames in order
    int                 n_push;
    int                 ver;                      // Label of the live version

    logic                    exp_valid;           // Response due next cycle
    rename_pkg::rename_rsp_t exp_rsp;
    logic [31:0]             lfsr_q;
    int                      errors;
    int                      checks;
    string                   test_name;

    // Stimulus for the coming cycle
    logic                      nx_valid;
    rename_pkg::rename_req_t   nx_req;
    rename_pkg::commit_t [1:0] nx_cmt;
    logic                      nx_recover;
    int                        nx_idx;            // Stack position to recover
    logic                      nx_delete;
    logic                      nx_rb;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int b = 0; b < n; b++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic chance(input int pct);
        return (int'(rand_bits(7)) % 100) < pct;
    endfunction

    // Free registers of a file including this cycle's commits
    function automatic int free_count(input int f);
        int n;
        n = ftail[f] - fhead[f];
        for (int k = 0; k < 2; k++) begin
            if (nx_cmt[k].valid && (int'(nx_cmt[k].fp) == f)) n++;
        end
        return n;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %0h actual %0h at %0t", test_name, what, exp, act,
                     $time);
        end
    endtask

    task automatic clear_next();
        logic [31:0] v;
        v          = rand_bits($bits(rename_pkg::rename_req_t));
        nx_valid   = 1'b0;
        nx_req     = v[$bits(rename_pkg::rename_req_t)-1:0];  // Random payload
        nx_cmt     = '0;
        nx_recover = 1'b0;
        nx_idx     = 0;
        nx_delete  = 1'b0;
        nx_rb      = 1'b0;
    endtask

    //////////////////////////////
    // One clock of stimulus, checks and model update
    //////////////////////////////

    task automatic run_cycle();
        rename_pkg::rename_req_t r;
        rename_pkg::rename_rsp_t e;
        rename_pkg::commit_t     c;
        logic                    fire;
        int                      lbl;
        int                      seq;
        @(posedge clk_i);
        rename_valid <= nx_valid;
        rename_req   <= nx_req;
        commit       <= nx_cmt;
        do_recover   <= nx_recover;
        recover_ckpt <= '0;
        if (nx_recover) recover_ckpt <= rename_pkg::checkpoint_ptr_t'(ck_lbl[nx_idx]);
        delete_ckpt  <= nx_delete;
        roll_back    <= nx_rb;
        @(negedge clk_i);                                  // Settled, away from the edge
        check("rsp_valid", 32'(exp_valid), 32'(rsp_valid));
        if (exp_valid && rsp_valid) check("rename_rsp", 32'(exp_rsp), 32'(rsp));
        check("out_of_checkpoints", 32'(ck_lbl.size() == NUM_CK - 1), 32'(ooc));
        check("empty_int", 32'(free_count(0) == 0), 32'(empty_int));
        check("empty_fp", 32'(free_count(1) == 0), 32'(empty_fp));

        r         = nx_req;
        fire      = nx_valid && !nx_recover && !nx_rb;   // Flush and recover drop the rename
        exp_valid = fire;
        if (nx_rb) begin
            for (int f = 0; f < 2; f++) begin
                for (int a = 0; a < 32; a++) smap[f][a] = cmap[f][a];
                fhead[f] = ftail[f] - 32;                  // Last 32 written are all free
            end
            ck_lbl.delete();
            ck_seq.delete();
            infl.delete();
            ver = 0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                c = nx_cmt[k];
                if (c.valid) begin
                    cmap[c.fp][c.dst]        = c.pdst;       // Slot 1 lands last
                    fbuf[c.fp][ftail[c.fp]] = c.old_pdst;
                    ftail[c.fp]++;
                end
            end
            if (nx_delete) begin
                void'(ck_lbl.pop_front());
                void'(ck_seq.pop_front());
            end
            if (nx_recover) begin
                lbl = ck_lbl[nx_idx];
                seq = ck_seq[nx_idx];
                while (ck_lbl.size() > nx_idx) begin      // Drop this branch and younger
                    void'(ck_lbl.pop_back());
                    void'(ck_seq.pop_back());
                end
                while (n_push > seq) begin                 // Squash wrong-path renames
                    void'(infl.pop_back());
                    n_push--;
                end
                for (int f = 0; f < 2; f++) begin
                    for (int a = 0; a < 32; a++) smap[f][a] = snap_map[f][lbl][a];
                    fhead[f] = snap_head[f][lbl];
                end
                ver = lbl;
            end else if (fire) begin
                e            = '0;
                e.psrc1      = smap[r.src1_fp][r.src1];
                e.psrc2      = smap[r.src2_fp][r.src2];
                e.old_pdst   = smap[r.dst_fp][r.dst];
                e.checkpoint = rename_pkg::checkpoint_ptr_t'(ver);
                if (r.dst_we && (r.dst_fp || (r.dst != '0))) begin   // x0 keeps p0
                    e.pdst      = fbuf[r.dst_fp][fhead[r.dst_fp]];   // Frees already pushed
                    e.dst_valid = 1'b1;
                    fhead[r.dst_fp]++;
                    smap[r.dst_fp][r.dst] = e.pdst;
                    c          = '0;
                    c.valid    = 1'b1;
                    c.fp       = r.dst_fp;
                    c.dst      = r.dst;
                    c.pdst     = e.pdst;
                    c.old_pdst = e.old_pdst;
                    infl.push_back(c);
                    n_push++;
                end
                if (r.do_checkpoint) begin
                    for (int f = 0; f < 2; f++) begin
                        for (int a = 0; a < 32; a++) snap_map[f][ver][a] = smap[f][a];
                        snap_head[f][ver] = fhead[f];
                    end
                    ck_lbl.push_back(ver);
                    ck_seq.push_back(n_push);
                    ver = (ver + 1) % NUM_CK;
                end
                exp_rsp = e;
            end
        end
    endtask

    //////////////////////////////
    // Stimulus builders
    //////////////////////////////

    task automatic random_cycle(input int p_ren, input int p_cmt, input int p_ckpt,
                                input int p_rec, input int p_del);
        int lim;
        int ready;
        clear_next();
        lim   = (ck_seq.size() == 0) ? n_push : ck_seq[0];   // Nothing past an open branch
        ready = lim - (n_push - infl.size());
        for (int k = 0; k < 2; k++) begin
            if ((k < ready) && ((k == 0) || nx_cmt[0].valid) && chance(p_cmt)) begin
                nx_cmt[k] = infl.pop_front();
            end
        end
        nx_recover = (ck_lbl.size() != 0) && chance(p_rec);
        if (nx_recover) nx_idx = int'(rand_bits(3)) % ck_lbl.size();
        nx_delete  = !nx_recover && (ck_lbl.size() != 0) && chance(p_del);
        nx_valid   = chance(p_ren);
        if (chance(10)) nx_req.dst = '0;                    // Extra x0 traffic
        nx_req.do_checkpoint = (ck_lbl.size() < NUM_CK - 1) && chance(p_ckpt);
        if (nx_req.dst_we && (nx_req.dst_fp || (nx_req.dst != '0))
            && (free_count(int'(nx_req.dst_fp)) == 0)) begin
            nx_req.dst_we = 1'b0;                           // Hold off on an empty list
        end
        run_cycle();
    endtask

    task automatic rollback_cycle();
        clear_next();
        nx_rb    = 1'b1;
        nx_valid = chance(50);                              // Rename lost to the flush
        run_cycle();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        lfsr_q       = 32'hed059a9c;
        errors       = 0;
        checks       = 0;
        rstn_i       = 1'b0;
        rename_valid = 1'b0;
        rename_req   = '0;
        commit       = '0;
        do_recover   = 1'b0;
        recover_ckpt = '0;
        delete_ckpt  = 1'b0;
        roll_back    = 1'b0;
        for (int f = 0; f < 2; f++) begin
            for (int a = 0; a < 32; a++) begin
                fbuf[f][a] = rename_pkg::phreg_t'(a + 32);  // Spares 32 to 63
                smap[f][a] = rename_pkg::phreg_t'(a);
                cmap[f][a] = rename_pkg::phreg_t'(a);
            end
            fhead[f] = 0;
            ftail[f] = 32;
        end
        n_push    = 0;
        ver       = 0;
        exp_valid = 1'b0;
        exp_rsp   = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;

        test_name = "reset_identity";
        for (int a = 1; a < 32; a++) begin
            clear_next();
            nx_valid             = 1'b1;
            nx_req.dst           = rename_pkg::areg_t'(a);
            nx_req.dst_we        = 1'b1;
            nx_req.dst_fp        = 1'b0;
            nx_req.do_checkpoint = 1'b0;
            run_cycle();
        end

        test_name = "random_rename";
        repeat (RAND_CYCLES) random_cycle(90, 25, 0, 0, 0);  // Drains lists to hit bypass

        test_name = "checkpoint_recover";
        repeat (CKPT_CYCLES) random_cycle(80, 35, 25, 8, 10);

        test_name = "rollback";
        repeat (RB_ROUNDS) begin
            repeat (RB_CYCLES) random_cycle(80, 35, 20, 5, 10);
            rollback_cycle();
        end

        clear_next();
        run_cycle();
        run_cycle();                                        // Last response checked here

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout after %0d cycles, stimulus never finished", TOTAL_CYCLES + 100);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_unit.f
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/rename_unit.sv
verif/tb_rename_unit.sv

// File: Makefile
TOP = tb_rename_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f rename_unit.f

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '=== PASS ==='

clean:
	rm -rf obj_dir
